// ==== sources.f ====
common/addmul_pkg.sv
design/addmul_slv.sv
addmul_pipe/addmul_mul_stage.sv
addmul_pipe/addmul_add_stage.sv
design/addmul_top.sv
testbench/addmul_asserts.sv
testbench/addmul_tb.sv

// ==== Makefile ====
TOP = addmul_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o addmul_sim
	./obj_dir/addmul_sim | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/addmul_tb.sv ====
`timescale 1ns/1ps

module addmul_tb;

  import addmul_pkg::*;

  localparam int N_LANES = 2;
  localparam int CLK_PERIOD = 8;
  localparam int ADDR_LSB = 2;
  localparam int ZERO_BEATS = 8;
  localparam int BURST_BEATS = 64;
  localparam int N_TRANSACTIONS = 24;
  localparam int TRANS_CYCLES = 16;
  localparam int MARGIN = 4;
  localparam int TIMEOUT_NS =
    (ZERO_BEATS + 3 * BURST_BEATS + N_TRANSACTIONS * TRANS_CYCLES) * MARGIN * CLK_PERIOD;

  // Every response is OKAY
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic                       aclk = 1'b0;
  logic                       aresetn;
  logic [AXIL_ADDR_BITS-1:0]  awaddr;
  logic                       awvalid;
  logic                       awready;
  logic [AXIL_DATA_BITS-1:0]  wdata;
  logic [3:0]                 wstrb;
  logic                       wvalid;
  logic                       wready;
  logic [1:0]                 bresp;
  logic                       bvalid;
  logic                       bready;
  logic [AXIL_ADDR_BITS-1:0]  araddr;
  logic                       arvalid;
  logic                       arready;
  logic [AXIL_DATA_BITS-1:0]  rdata;
  logic [1:0]                 rresp;
  logic                       rvalid;
  logic                       rready;
  logic                       s_valid;
  logic                       s_last;
  lane_t [N_LANES-1:0]        s_data;
  logic                       m_valid;
  logic                       m_last;
  lane_t [N_LANES-1:0]        m_data;

  // Expected register contents and stream
  logic [AXIL_DATA_BITS-1:0]  reg_model [2];
  logic [31:0]                lcg_state;
  lane_t                      exp_lane_q [$];
  logic                       exp_last_q [$];

  int beats_in = 0;
  int beats_out = 0;
  int lane_errors = 0;
  int last_errors = 0;
  int stream_errors = 0;
  int rdata_errors = 0;
  int resp_errors = 0;
  int protocol_errors = 0;

  addmul_top #(
    .N_LANES (N_LANES)
  ) u_addmul_top (
    .aclk (aclk), .aresetn (aresetn),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .s_valid (s_valid), .s_last (s_last), .s_data (s_data),
    .m_valid (m_valid), .m_last (m_last), .m_data (m_data)
  );

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [AXIL_ADDR_BITS-1:0] reg_addr(input addmul_reg_e idx);
    return {idx, 2'b00};
  endfunction

  // Low word of data times the low half of the multiply register, plus the add half
  function automatic lane_t ref_lane(input lane_t din);
    lane_t mul_ext;
    lane_t add_ext;
    mul_ext = {{(LANE_BITS-FACTOR_BITS){1'b0}}, reg_model[REG_MUL_FACT][FACTOR_BITS-1:0]};
    add_ext = {{(LANE_BITS-FACTOR_BITS){1'b0}}, reg_model[REG_ADD_FACT][FACTOR_BITS-1:0]};
    return din * mul_ext + add_ext;
  endfunction

  // Unaligned addresses read as zero
  function automatic logic [AXIL_DATA_BITS-1:0] expected_read(
    input logic [AXIL_ADDR_BITS-1:0] addr);
    if (addr[ADDR_LSB-1:0] != '0)
      return '0;
    return reg_model[addr[AXIL_ADDR_BITS-1:ADDR_LSB]];
  endfunction

  task automatic check_lane(input lane_t got, input lane_t exp, input int beat, input int lane);
    if (got !== exp)
    begin
      lane_errors++;
      $display("error at %0t ns: beat %0d lane %0d is %h, expected %h",
               $time, beat, lane, got, exp);
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input int beat);
    if (got !== exp)
    begin
      last_errors++;
      $display("error at %0t ns: beat %0d last is %b, expected %b", $time, beat, got, exp);
    end
  endtask

  task automatic check_rdata(input logic [AXIL_DATA_BITS-1:0] got,
                             input logic [AXIL_DATA_BITS-1:0] exp,
                             input logic [AXIL_ADDR_BITS-1:0] addr);
    if (got !== exp)
    begin
      rdata_errors++;
      $display("error at %0t ns: read of address %0d gave %h, expected %h",
               $time, addr, got, exp);
    end
  endtask

  task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string chan);
    if (got !== exp)
    begin
      resp_errors++;
      $display("error at %0t ns: %s response is %b, expected %b", $time, chan, got, exp);
    end
  endtask

  // ------------------------------------------------------------
  // AXI4-Lite driver
  // ------------------------------------------------------------

  task automatic axil_write(input logic [AXIL_ADDR_BITS-1:0] addr,
                            input logic [AXIL_DATA_BITS-1:0] data,
                            input logic [3:0] strb, input int hold);
    @(negedge aclk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    do @(negedge aclk); while (!(awready && wready));
    @(negedge aclk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid)
      @(negedge aclk);
    repeat (hold)
    begin
      @(negedge aclk);
      if (!bvalid)
      begin
        protocol_errors++;
        $display("Write response went away before bready was raised");
      end
    end
    check_resp(bresp, RESP_OKAY, "write");
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
    // Byte merge into the expected register
    if (addr[ADDR_LSB-1:0] == '0)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (strb[i])
          reg_model[addr[AXIL_ADDR_BITS-1:ADDR_LSB]][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endtask

  task automatic check_read(input logic [AXIL_ADDR_BITS-1:0] addr, input int hold);
    logic [AXIL_DATA_BITS-1:0] data;
    @(negedge aclk);
    araddr  = addr;
    arvalid = 1'b1;
    do @(negedge aclk); while (!arready);
    @(negedge aclk);
    arvalid = 1'b0;
    while (!rvalid)
      @(negedge aclk);
    repeat (hold)
    begin
      @(negedge aclk);
      if (!rvalid)
      begin
        protocol_errors++;
        $display("Read data went away before rready was raised");
      end
    end
    data   = rdata;
    check_resp(rresp, RESP_OKAY, "read");
    rready = 1'b1;
    @(negedge aclk);
    rready = 1'b0;
    check_rdata(data, expected_read(addr), addr);
  endtask

  // ------------------------------------------------------------
  // Stream stimulus and comparison
  // ------------------------------------------------------------

  // Back-to-back beats, then wait for the pipeline to drain
  task automatic send_burst(input int n_beats);
    logic [31:0] r;
    for (int b = 0; b < n_beats; b++)
    begin
      @(negedge aclk);
      for (int l = 0; l < N_LANES; l++)
      begin
        s_data[l] = lcg_next();
        exp_lane_q.push_back(ref_lane(s_data[l]));
      end
      r = lcg_next();
      s_valid = 1'b1;
      s_last  = (b == n_beats - 1) || r[31];
      exp_last_q.push_back(s_last);
      beats_in++;
    end
    @(negedge aclk);
    s_valid = 1'b0;
    s_last  = 1'b0;
    while (exp_last_q.size() != 0)
      @(negedge aclk);
  endtask

  always @(negedge aclk)
  begin
    lane_t exp_lane;
    logic  exp_last;
    if (aresetn && m_valid)
    begin
      if (exp_last_q.size() == 0)
      begin
        stream_errors++;
        $display("Output beat %0d arrived with no input beat behind it", beats_out);
      end
      else
      begin
        for (int l = 0; l < N_LANES; l++)
        begin
          exp_lane = exp_lane_q.pop_front();
          check_lane(m_data[l], exp_lane, beats_out, l);
        end
        exp_last = exp_last_q.pop_front();
        check_last(m_last, exp_last, beats_out);
      end
      beats_out++;
    end
  end

  // Watchdog
  initial
  begin
    #(TIMEOUT_NS);
    $display("Simulation did not finish within %0d ns", TIMEOUT_NS);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    int total;
    aresetn = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    s_valid = 1'b0;
    s_last  = 1'b0;
    s_data  = '0;
    lcg_state = 32'd28;
    reg_model[0] = '0;
    reg_model[1] = '0;
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    // Reset values, then a stream through zero factors
    if (awready || wready || bvalid || arready || rvalid || m_valid)
    begin
      protocol_errors++;
      $display("Handshake outputs are not all low after reset");
    end
    check_read(reg_addr(REG_MUL_FACT), 0);
    check_read(reg_addr(REG_ADD_FACT), 0);
    send_burst(ZERO_BEATS);

    // Full-word writes
    axil_write(reg_addr(REG_MUL_FACT), 32'hA5C3_0007, 4'b1111, 0);
    axil_write(reg_addr(REG_ADD_FACT), 32'h1234_0100, 4'b1111, 0);
    check_read(reg_addr(REG_MUL_FACT), 0);
    check_read(reg_addr(REG_ADD_FACT), 0);

    // Byte strobes, and an unaligned word that maps to nothing
    axil_write(reg_addr(REG_MUL_FACT), 32'hFFFF_FF42, 4'b0001, 0);
    axil_write(reg_addr(REG_MUL_FACT), 32'hFFFF_99FF, 4'b0010, 0);
    check_read(reg_addr(REG_MUL_FACT), 0);
    axil_write(3'd6, 32'hDEAD_BEEF, 4'b1111, 0);
    check_read(3'd6, 0);
    check_read(reg_addr(REG_ADD_FACT), 0);

    send_burst(BURST_BEATS);

    // New factors between bursts
    axil_write(reg_addr(REG_MUL_FACT), lcg_next(), 4'b1111, 0);
    axil_write(reg_addr(REG_ADD_FACT), lcg_next(), 4'b1111, 0);
    send_burst(BURST_BEATS);

    // Stalled responses
    axil_write(reg_addr(REG_ADD_FACT), 32'h0000_FFFF, 4'b1111, 6);
    check_read(reg_addr(REG_ADD_FACT), 6);
    check_read(reg_addr(REG_MUL_FACT), 3);
    send_burst(16);

    repeat (4) @(negedge aclk);
    if (beats_out != beats_in)
    begin
      protocol_errors++;
      $display("Sent %0d beats but received %0d", beats_in, beats_out);
    end
    total = lane_errors + last_errors + stream_errors + rdata_errors + resp_errors
            + protocol_errors + u_addmul_top.u_asserts.assert_errors;
    $display("Errors: lane %0d last %0d stream %0d rdata %0d resp %0d protocol %0d assert %0d",
             lane_errors, last_errors, stream_errors, rdata_errors, resp_errors,
             protocol_errors, u_addmul_top.u_asserts.assert_errors);
    if (total == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== testbench/addmul_asserts.sv ====
`timescale 1ns/1ps

module addmul_asserts (
  input logic aclk,
  input logic aresetn,
  input logic awvalid,
  input logic awready,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic s_valid,
  input logic m_valid
);

  // Failure count, summed into the final result
  int assert_errors = 0;

  // ------------------------------------------------------------
  // AXI4-Lite handshake
  // ------------------------------------------------------------

  a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid)
  else
  begin
    assert_errors++;
    $error("bvalid dropped before bready");
  end

  a_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid)
  else
  begin
    assert_errors++;
    $error("rvalid dropped before rready");
  end

  a_awready_req: assert property (@(posedge aclk) disable iff (!aresetn)
    awready |-> awvalid)
  else
  begin
    assert_errors++;
    $error("awready high without awvalid");
  end

  // Two-cycle stream latency
  a_beat_out: assert property (@(posedge aclk) disable iff (!aresetn)
    s_valid |-> ##2 m_valid)
  else
  begin
    assert_errors++;
    $error("m_valid missing two cycles after s_valid");
  end

  a_idle_out: assert property (@(posedge aclk) disable iff (!aresetn)
    !s_valid |-> ##2 !m_valid)
  else
  begin
    assert_errors++;
    $error("m_valid without s_valid two cycles before");
  end

endmodule

bind addmul_top addmul_asserts u_asserts (
  .aclk    (aclk),
  .aresetn (aresetn),
  .awvalid (awvalid),
  .awready (awready),
  .bvalid  (bvalid),
  .bready  (bready),
  .rvalid  (rvalid),
  .rready  (rready),
  .s_valid (s_valid),
  .m_valid (m_valid)
);

// ==== design/addmul_top.sv ====
`timescale 1ns/1ps

module addmul_top #(
  parameter int N_LANES = 2
) (
  input  logic                                     aclk,
  input  logic                                     aresetn,

  // AXI4-Lite control
  input  logic [addmul_pkg::AXIL_ADDR_BITS-1:0]    awaddr,
  input  logic                                     awvalid,
  output logic                                     awready,
  input  logic [addmul_pkg::AXIL_DATA_BITS-1:0]    wdata,
  input  logic [addmul_pkg::AXIL_DATA_BITS/8-1:0]  wstrb,
  input  logic                                     wvalid,
  output logic                                     wready,
  output logic [1:0]                               bresp,
  output logic                                     bvalid,
  input  logic                                     bready,
  input  logic [addmul_pkg::AXIL_ADDR_BITS-1:0]    araddr,
  input  logic                                     arvalid,
  output logic                                     arready,
  output logic [addmul_pkg::AXIL_DATA_BITS-1:0]    rdata,
  output logic [1:0]                               rresp,
  output logic                                     rvalid,
  input  logic                                     rready,

  // Data stream
  input  logic                                     s_valid,
  input  logic                                     s_last,
  input  addmul_pkg::lane_t [N_LANES-1:0]          s_data,
  output logic                                     m_valid,
  output logic                                     m_last,
  output addmul_pkg::lane_t [N_LANES-1:0]          m_data
);

  import addmul_pkg::*;

  factor_t               mul_factor;
  factor_t               add_factor;

  // Between the two pipeline stages
  logic                  mid_valid;
  logic                  mid_last;
  lane_t [N_LANES-1:0]   mid_data;

  addmul_slv u_slv (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .mul_factor (mul_factor),
    .add_factor (add_factor)
  );

  addmul_mul_stage #(
    .N_LANES (N_LANES)
  ) u_mul (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .mul_factor (mul_factor),
    .s_valid    (s_valid),
    .s_last     (s_last),
    .s_data     (s_data),
    .mid_valid  (mid_valid),
    .mid_last   (mid_last),
    .mid_data   (mid_data)
  );

  addmul_add_stage #(
    .N_LANES (N_LANES)
  ) u_add (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .add_factor (add_factor),
    .mid_valid  (mid_valid),
    .mid_last   (mid_last),
    .mid_data   (mid_data),
    .m_valid    (m_valid),
    .m_last     (m_last),
    .m_data     (m_data)
  );

endmodule

// ==== addmul_pipe/addmul_add_stage.sv ====
`timescale 1ns/1ps

module addmul_add_stage #(
  parameter int N_LANES = 2
) (
  input  logic                              aclk,
  input  logic                              aresetn,

  input  addmul_pkg::factor_t               add_factor,

  // Stream from the multiply stage
  input  logic                              mid_valid,
  input  logic                              mid_last,
  input  addmul_pkg::lane_t [N_LANES-1:0]   mid_data,

  // Stream out
  output logic                              m_valid,
  output logic                              m_last,
  output addmul_pkg::lane_t [N_LANES-1:0]   m_data
);

  import addmul_pkg::*;

  lane_t                 factor_ext;
  lane_t [N_LANES-1:0]   sum;

  assign factor_ext = lane_t'(add_factor);

  // Lane-wise add, wraps modulo 2^32
  always_comb
  begin
    for (int i = 0; i < N_LANES; i++)
      sum[i] = mid_data[i] + factor_ext;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      m_valid <= 1'b0;
    else
      m_valid <= mid_valid;
  end

  always_ff @(posedge aclk)
  begin
    m_last <= mid_last;
    if (mid_valid)
      m_data <= sum;
  end

endmodule

// ==== addmul_pipe/addmul_mul_stage.sv ====
`timescale 1ns/1ps

module addmul_mul_stage #(
  parameter int N_LANES = 2
) (
  input  logic                              aclk,
  input  logic                              aresetn,

  input  addmul_pkg::factor_t               mul_factor,

  // Stream in
  input  logic                              s_valid,
  input  logic                              s_last,
  input  addmul_pkg::lane_t [N_LANES-1:0]   s_data,

  // Stream to the add stage
  output logic                              mid_valid,
  output logic                              mid_last,
  output addmul_pkg::lane_t [N_LANES-1:0]   mid_data
);

  import addmul_pkg::*;

  lane_t                 factor_ext;
  lane_t [N_LANES-1:0]   product;

  // Zero-extended so the product keeps only the low lane bits
  assign factor_ext = lane_t'(mul_factor);

  always_comb
  begin
    for (int i = 0; i < N_LANES; i++)
      product[i] = s_data[i] * factor_ext;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      mid_valid <= 1'b0;
    else
      mid_valid <= s_valid;
  end

  // Payload, loaded on valid beats only
  always_ff @(posedge aclk)
  begin
    mid_last <= s_last;
    if (s_valid)
      mid_data <= product;
  end

endmodule

// ==== design/addmul_slv.sv ====
`timescale 1ns/1ps

module addmul_slv (
  input  logic                                     aclk,
  input  logic                                     aresetn,

  // Write address
  input  logic [addmul_pkg::AXIL_ADDR_BITS-1:0]    awaddr,
  input  logic                                     awvalid,
  output logic                                     awready,

  // Write data
  input  logic [addmul_pkg::AXIL_DATA_BITS-1:0]    wdata,
  input  logic [addmul_pkg::AXIL_DATA_BITS/8-1:0]  wstrb,
  input  logic                                     wvalid,
  output logic                                     wready,

  // Write response
  output logic [1:0]                               bresp,
  output logic                                     bvalid,
  input  logic                                     bready,

  // Read address
  input  logic [addmul_pkg::AXIL_ADDR_BITS-1:0]    araddr,
  input  logic                                     arvalid,
  output logic                                     arready,

  // Read data
  output logic [addmul_pkg::AXIL_DATA_BITS-1:0]    rdata,
  output logic [1:0]                               rresp,
  output logic                                     rvalid,
  input  logic                                     rready,

  // Factors to the pipeline
  output addmul_pkg::factor_t                      mul_factor,
  output addmul_pkg::factor_t                      add_factor
);

  import addmul_pkg::*;

  // ------------------------------------------------------------
  // Declarations
  // ------------------------------------------------------------

  localparam int N_REGS = 2;
  localparam int STRB_BITS = AXIL_DATA_BITS / 8;
  localparam int ADDR_LSB = $clog2(STRB_BITS);

  // Responses are always OKAY
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic [N_REGS-1:0][AXIL_DATA_BITS-1:0] slv_reg;

  logic [AXIL_ADDR_BITS-1:0] awaddr_q;
  logic [AXIL_ADDR_BITS-1:0] araddr_q;

  // Cleared while a write is in flight, set again once the response is taken
  logic aw_en;

  logic        wr_en;
  logic        rd_en;
  addmul_reg_e wr_idx;
  addmul_reg_e rd_idx;
  logic        wr_hit;
  logic        rd_hit;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------

  assign wr_idx = addmul_reg_e'(awaddr_q[AXIL_ADDR_BITS-1:ADDR_LSB]);
  assign rd_idx = addmul_reg_e'(araddr_q[AXIL_ADDR_BITS-1:ADDR_LSB]);

  // Unaligned byte addresses do not hit a register
  assign wr_hit = (awaddr_q[ADDR_LSB-1:0] == '0);
  assign rd_hit = (araddr_q[ADDR_LSB-1:0] == '0);

  assign wr_en = awready && awvalid && wready && wvalid;
  assign rd_en = arready && arvalid && !rvalid;

  // ------------------------------------------------------------
  // Write channel
  // ------------------------------------------------------------

  // awready and wready pulse together for one cycle
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      aw_en   <= 1'b1;
    end
    else if (!awready && awvalid && wvalid && aw_en)
    begin
      awready <= 1'b1;
      wready  <= 1'b1;
      aw_en   <= 1'b0;
    end
    else
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
      if (bvalid && bready)
        aw_en <= 1'b1;
    end
  end

  // Address held for the handshake cycle
  always_ff @(posedge aclk)
  begin
    if (!awready && awvalid && wvalid && aw_en)
      awaddr_q <= awaddr;
  end

  // Byte-strobed register update
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      slv_reg <= '0;
    else if (wr_en && wr_hit)
    begin
      for (int i = 0; i < STRB_BITS; i++)
      begin
        if (wstrb[i])
          slv_reg[wr_idx][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      bvalid <= 1'b0;
    else if (wr_en && !bvalid)
      bvalid <= 1'b1;
    else if (bvalid && bready)
      bvalid <= 1'b0;
  end

  assign bresp = RESP_OKAY;

  // ------------------------------------------------------------
  // Read channel
  // ------------------------------------------------------------

  // No new read while the previous data waits for rready
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      arready <= 1'b0;
    else
      arready <= !arready && arvalid && !rvalid;
  end

  always_ff @(posedge aclk)
  begin
    if (!arready && arvalid && !rvalid)
      araddr_q <= araddr;
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      rvalid <= 1'b0;
    else if (rd_en)
      rvalid <= 1'b1;
    else if (rvalid && rready)
      rvalid <= 1'b0;
  end

  // Unmapped reads give zero
  always_ff @(posedge aclk)
  begin
    if (rd_en)
      rdata <= rd_hit ? slv_reg[rd_idx] : '0;
  end

  assign rresp = RESP_OKAY;

  // Factors are the low halves of the registers
  assign mul_factor = slv_reg[REG_MUL_FACT][FACTOR_BITS-1:0];
  assign add_factor = slv_reg[REG_ADD_FACT][FACTOR_BITS-1:0];

endmodule

// ==== common/addmul_pkg.sv ====
package addmul_pkg;

  // ------------------------------------------------------------
  // Bus and datapath widths
  // ------------------------------------------------------------

  // AXI4-Lite control bus
  parameter int AXIL_DATA_BITS = 32;
  // Two 4-byte registers
  parameter int AXIL_ADDR_BITS = 3;

  // Datapath
  parameter int FACTOR_BITS = 16;
  parameter int LANE_BITS = 32;

  // ------------------------------------------------------------
  // Register map
  // ------------------------------------------------------------

  // Word index above the byte offset
  typedef enum logic [0:0] {
    REG_MUL_FACT = 1'b0,
    REG_ADD_FACT = 1'b1
  } addmul_reg_e;

  // One stream lane, unsigned
  typedef logic [LANE_BITS-1:0] lane_t;

  // One configuration factor
  typedef logic [FACTOR_BITS-1:0] factor_t;

endpackage
